//--- common/ctrl_pkg.sv
package ctrl_pkg;

  ////////////////////////////////////////
  // Bus and register file geometry
  ////////////////////////////////////////
  localparam int WORD_W    = 32;
  localparam int ADDR_W    = 32;
  localparam int NUM_REGS  = 8;
  localparam int REG_IDX_W = $clog2(NUM_REGS);
  localparam int IDX_LSB   = 2;  // Word addressing, index in addr[4:2]

  // Host register map
  typedef enum logic [REG_IDX_W-1:0] {
    REG_KCMD      = 3'd0,  // Write launches a command
    REG_CMD       = 3'd1,
    REG_DATA0     = 3'd2,
    REG_DATA1     = 3'd3,
    REG_DELAY     = 3'd4,  // Launch delay in cycles
    REG_WDT_KICK  = 3'd5,
    REG_WDT_START = 3'd6,  // Bit 0 enables watchdog
    REG_SPARE     = 3'd7
  } reg_idx_e;

  localparam logic [WORD_W-1:0] KCMD_RESET_VAL = 32'hDEADBEEF;
  localparam logic [1:0]        RESP_OKAY      = 2'b00;

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////
  // Scaled for simulation, silicon used 3 s at 50 MHz
  localparam int WDT_CNT_W   = 32;
  localparam int WDT_PULSE_W = 16;

  localparam logic [WDT_CNT_W-1:0]   WDT_TIMEOUT_CYCLES = 32'd150;
  localparam logic [WDT_PULSE_W-1:0] WDT_PULSE_CYCLES   = 16'd20;

endpackage

//--- regs/axil_reg_slave.sv
module axil_reg_slave (
  input  logic                          clk,
  input  logic                          rstn,
  // Write address / data / response
  input  logic [ctrl_pkg::ADDR_W-1:0]   awaddr_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [ctrl_pkg::WORD_W-1:0]   wdata_i,
  input  logic [ctrl_pkg::WORD_W/8-1:0] wstrb_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  output logic [1:0]                    bresp_o,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  // Read address / data
  input  logic [ctrl_pkg::ADDR_W-1:0]   araddr_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  output logic [ctrl_pkg::WORD_W-1:0]   rdata_o,
  output logic [1:0]                    rresp_o,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  // Core status words
  input  logic [ctrl_pkg::WORD_W-1:0]   status0_i,
  input  logic [ctrl_pkg::WORD_W-1:0]   status1_i,
  input  logic [ctrl_pkg::WORD_W-1:0]   status2_i,
  input  logic [ctrl_pkg::WORD_W-1:0]   status3_i,
  // To launcher and watchdog
  output logic                          cmd_new_o,
  output logic [ctrl_pkg::WORD_W-1:0]   cmd_o,
  output logic [ctrl_pkg::WORD_W-1:0]   data0_o,
  output logic [ctrl_pkg::WORD_W-1:0]   data1_o,
  output logic [ctrl_pkg::WORD_W-1:0]   delay_o,
  output logic                          wdt_kick_o,
  output logic                          wdt_start_o
);

  logic                        waddr_got_q;
  logic                        wdata_got_q;
  logic                        commit;
  ctrl_pkg::reg_idx_e          widx_q;
  ctrl_pkg::reg_idx_e          ridx;
  logic [ctrl_pkg::WORD_W-1:0] wdat_q;
  logic [ctrl_pkg::WORD_W-1:0] kcmd_q;
  logic [ctrl_pkg::WORD_W-1:0] cmd_q;
  logic [ctrl_pkg::WORD_W-1:0] data0_q;
  logic [ctrl_pkg::WORD_W-1:0] data1_q;
  logic [ctrl_pkg::WORD_W-1:0] delay_q;
  logic [ctrl_pkg::WORD_W-1:0] rdata_q;
  logic [ctrl_pkg::WORD_W-1:0] rd_word;

  assign commit = waddr_got_q && wdata_got_q;
  assign ridx   = ctrl_pkg::reg_idx_e'(araddr_i[ctrl_pkg::IDX_LSB +: ctrl_pkg::REG_IDX_W]);

  ////////////////////////////////////////
  // Read channel
  ////////////////////////////////////////
  // Indices 1 to 4 return core status, not the stored arguments
  always_comb begin
    case (ridx)
      ctrl_pkg::REG_KCMD:  rd_word = kcmd_q;
      ctrl_pkg::REG_CMD:   rd_word = status0_i;
      ctrl_pkg::REG_DATA0: rd_word = status1_i;
      ctrl_pkg::REG_DATA1: rd_word = status2_i;
      ctrl_pkg::REG_DELAY: rd_word = status3_i;
      default:             rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      arready_o <= 1'b1;
      rvalid_o  <= 1'b0;
    end else if (arready_o && arvalid_i) begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b1;
    end else if (rvalid_o && rready_i) begin
      rvalid_o  <= 1'b0;
      arready_o <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (arready_o && arvalid_i) rdata_q <= rd_word;  // Held through stall
  end

  assign rdata_o = rdata_q;
  assign rresp_o = ctrl_pkg::RESP_OKAY;

  ////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      awready_o   <= 1'b1;
      wready_o    <= 1'b1;
      waddr_got_q <= 1'b0;
      wdata_got_q <= 1'b0;
      bvalid_o    <= 1'b0;
      cmd_new_o   <= 1'b0;
      wdt_kick_o  <= 1'b0;
      wdt_start_o <= 1'b0;
      kcmd_q      <= ctrl_pkg::KCMD_RESET_VAL;
    end else begin
      cmd_new_o  <= 1'b0;
      wdt_kick_o <= 1'b0;
      if (awready_o && awvalid_i) begin
        awready_o   <= 1'b0;
        waddr_got_q <= 1'b1;
      end
      if (wready_o && wvalid_i) begin
        wready_o    <= 1'b0;
        wdata_got_q <= 1'b1;
      end
      if (commit) begin
        waddr_got_q <= 1'b0;
        wdata_got_q <= 1'b0;
        bvalid_o    <= 1'b1;
        case (widx_q)
          ctrl_pkg::REG_KCMD: begin
            kcmd_q    <= wdat_q;
            cmd_new_o <= 1'b1;
          end
          ctrl_pkg::REG_WDT_KICK:  wdt_kick_o  <= |wdat_q;
          ctrl_pkg::REG_WDT_START: wdt_start_o <= wdat_q[0];
          default: ;
        endcase
      end
      if (bvalid_o && bready_i) begin
        bvalid_o  <= 1'b0;
        awready_o <= 1'b1;  // Next write only after B
        wready_o  <= 1'b1;
      end
    end
  end

  // Captured address/data and argument words
  always_ff @(posedge clk) begin
    if (awready_o && awvalid_i) begin
      widx_q <= ctrl_pkg::reg_idx_e'(awaddr_i[ctrl_pkg::IDX_LSB +: ctrl_pkg::REG_IDX_W]);
    end
    if (wready_o && wvalid_i) wdat_q <= wdata_i;
    if (commit) begin
      case (widx_q)
        ctrl_pkg::REG_CMD:   cmd_q   <= wdat_q;
        ctrl_pkg::REG_DATA0: data0_q <= wdat_q;
        ctrl_pkg::REG_DATA1: data1_q <= wdat_q;
        ctrl_pkg::REG_DELAY: delay_q <= wdat_q;
        default: ;
      endcase
    end
  end

  assign bresp_o = ctrl_pkg::RESP_OKAY;
  assign cmd_o   = cmd_q;
  assign data0_o = data0_q;
  assign data1_o = data1_q;
  assign delay_o = delay_q;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  a_rvalid_hold : assert property (@(posedge clk) disable iff (!rstn)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));

  a_bvalid_hold : assert property (@(posedge clk) disable iff (!rstn)
    bvalid_o && !bready_i |=> bvalid_o);

  a_cmd_new_single : assert property (@(posedge clk) disable iff (!rstn)
    cmd_new_o |=> !cmd_new_o);

endmodule

//--- design/cmd_launch.sv
module cmd_launch (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        cmd_new_i,
  input  logic [ctrl_pkg::WORD_W-1:0] cmd_i,
  input  logic [ctrl_pkg::WORD_W-1:0] data0_i,
  input  logic [ctrl_pkg::WORD_W-1:0] data1_i,
  input  logic [ctrl_pkg::WORD_W-1:0] delay_i,
  output logic                        cmd_valid_o,
  output logic [ctrl_pkg::WORD_W-1:0] cmd_o,
  output logic [ctrl_pkg::WORD_W-1:0] data0_o,
  output logic [ctrl_pkg::WORD_W-1:0] data1_o
);

  logic [ctrl_pkg::WORD_W-1:0] count_q;
  logic                        active_q;

  // Countdown, a new request restarts it
  always_ff @(posedge clk) begin
    if (!rstn) begin
      active_q <= 1'b0;
      count_q  <= '0;
    end else if (cmd_new_i) begin
      active_q <= 1'b1;
      count_q  <= delay_i;
    end else if (active_q) begin
      if (count_q == '0) begin
        active_q <= 1'b0;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign cmd_valid_o = active_q && (count_q == '0);  // DELAY+1 after request

  // Payload is whatever the registers hold at expiry
  assign cmd_o   = cmd_i;
  assign data0_o = data0_i;
  assign data1_o = data1_i;

  // Only a fresh request in the firing cycle may re-fire at once
  a_valid_one_cycle : assert property (@(posedge clk) disable iff (!rstn)
    cmd_valid_o && !cmd_new_i |=> !cmd_valid_o);

endmodule

//--- watchdog/watchdog_timer.sv
module watchdog_timer (
  input  logic clk,
  input  logic rstn,
  input  logic start_i,
  input  logic kick_i,
  input  logic button_i,
  output logic core_rst_o
);

  logic [ctrl_pkg::WDT_CNT_W-1:0]   count_q;
  logic [ctrl_pkg::WDT_PULSE_W-1:0] pulse_q;
  logic                             pulse_on;
  logic                             rst_q;

  assign pulse_on = (pulse_q != '0);

  ////////////////////////////////////////
  // Liveness counter and pulse length
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      count_q <= '0;
      pulse_q <= '0;
    end else begin
      if (pulse_on) pulse_q <= pulse_q - 1'b1;

      if (start_i && !kick_i) begin
        if (count_q < ctrl_pkg::WDT_TIMEOUT_CYCLES - 1'b1) begin
          count_q <= count_q + 1'b1;
        end else begin
          count_q <= '0;
          pulse_q <= ctrl_pkg::WDT_PULSE_CYCLES;  // Host went quiet
        end
      end else begin
        count_q <= '0;  // Kicked or disabled
      end
    end
  end

  // Manual button ORed in
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rst_q <= 1'b0;
    end else begin
      rst_q <= pulse_on | button_i;
    end
  end

  assign core_rst_o = rst_q;

  a_pulse_bound : assert property (@(posedge clk) disable iff (!rstn)
    pulse_q <= ctrl_pkg::WDT_PULSE_CYCLES);

endmodule

//--- design/ctrl_top.sv
module ctrl_top (
  input  logic                          clk,
  input  logic                          rstn,
  // AXI-Lite slave port
  input  logic [ctrl_pkg::ADDR_W-1:0]   awaddr_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [ctrl_pkg::WORD_W-1:0]   wdata_i,
  input  logic [ctrl_pkg::WORD_W/8-1:0] wstrb_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  output logic [1:0]                    bresp_o,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  input  logic [ctrl_pkg::ADDR_W-1:0]   araddr_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  output logic [ctrl_pkg::WORD_W-1:0]   rdata_o,
  output logic [1:0]                    rresp_o,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  // Core side
  input  logic [ctrl_pkg::WORD_W-1:0]   status0_i,
  input  logic [ctrl_pkg::WORD_W-1:0]   status1_i,
  input  logic [ctrl_pkg::WORD_W-1:0]   status2_i,
  input  logic [ctrl_pkg::WORD_W-1:0]   status3_i,
  input  logic                          button_i,
  output logic                          cmd_valid_o,
  output logic [ctrl_pkg::WORD_W-1:0]   cmd_o,
  output logic [ctrl_pkg::WORD_W-1:0]   data0_o,
  output logic [ctrl_pkg::WORD_W-1:0]   data1_o,
  output logic                          core_rst_o
);

  logic                        cmd_new;
  logic [ctrl_pkg::WORD_W-1:0] cmd;
  logic [ctrl_pkg::WORD_W-1:0] data0;
  logic [ctrl_pkg::WORD_W-1:0] data1;
  logic [ctrl_pkg::WORD_W-1:0] delay;
  logic                        wdt_kick;
  logic                        wdt_start;

  axil_reg_slave u_regs (
    .clk         (clk),
    .rstn        (rstn),
    .awaddr_i    (awaddr_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .bresp_o     (bresp_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .araddr_i    (araddr_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .status0_i   (status0_i),
    .status1_i   (status1_i),
    .status2_i   (status2_i),
    .status3_i   (status3_i),
    .cmd_new_o   (cmd_new),
    .cmd_o       (cmd),
    .data0_o     (data0),
    .data1_o     (data1),
    .delay_o     (delay),
    .wdt_kick_o  (wdt_kick),
    .wdt_start_o (wdt_start)
  );

  cmd_launch u_launch (
    .clk         (clk),
    .rstn        (rstn),
    .cmd_new_i   (cmd_new),
    .cmd_i       (cmd),
    .data0_i     (data0),
    .data1_i     (data1),
    .delay_i     (delay),
    .cmd_valid_o (cmd_valid_o),
    .cmd_o       (cmd_o),
    .data0_o     (data0_o),
    .data1_o     (data1_o)
  );

  watchdog_timer u_wdt (
    .clk        (clk),
    .rstn       (rstn),
    .start_i    (wdt_start),
    .kick_i     (wdt_kick),
    .button_i   (button_i),
    .core_rst_o (core_rst_o)
  );

endmodule

//--- tests/tb_ctrl_top.sv
module tb_ctrl_top;

  localparam int WAIT_LIMIT = 50;

  logic                          clk;
  logic                          rstn;
  logic [ctrl_pkg::ADDR_W-1:0]   awaddr_i, araddr_i;
  logic [ctrl_pkg::WORD_W-1:0]   wdata_i;
  logic [ctrl_pkg::WORD_W/8-1:0] wstrb_i;
  logic                          awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
  logic                          awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
  logic [1:0]                    bresp_o, rresp_o;
  logic [ctrl_pkg::WORD_W-1:0]   rdata_o;
  logic [ctrl_pkg::WORD_W-1:0]   status0_i, status1_i, status2_i, status3_i;
  logic                          button_i, cmd_valid_o, core_rst_o;
  logic [ctrl_pkg::WORD_W-1:0]   cmd_o, data0_o, data1_o;

  int                          assert_errs = 0;
  int                          check_errs  = 0;
  int                          timeouts    = 0;
  int                          cycle       = 0;
  int                          resp_at     = 0;   // Cycle bvalid last rose
  int                          fire_at     = -1;  // Cycle the launch is due
  logic                        quiet;             // core_rst_o must stay low
  logic [31:0]                 rng;
  logic [ctrl_pkg::WORD_W-1:0] exp_kcmd, exp_cmd, exp_data0, exp_data1, exp_delay;

  ctrl_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      check_errs++;
      $display("error %s got %h expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // AXI-Lite master
  ////////////////////////////////////////
  task automatic axil_write(input logic [2:0] idx, input logic [31:0] data);
    int n;
    case (idx)
      ctrl_pkg::REG_KCMD:  exp_kcmd  = data;
      ctrl_pkg::REG_CMD:   exp_cmd   = data;
      ctrl_pkg::REG_DATA0: exp_data0 = data;
      ctrl_pkg::REG_DATA1: exp_data1 = data;
      ctrl_pkg::REG_DELAY: exp_delay = data;
      default: ;
    endcase
    awaddr_i  = 32'(idx) << ctrl_pkg::IDX_LSB;
    wdata_i   = data;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    n = 0;
    while (!(awready_o && wready_o) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!(awready_o && wready_o)) begin
      timeouts++;
      $display("timeout: write address or data channel never became ready");
    end
    @(negedge clk);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    n = 0;
    while (!bvalid_o && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!bvalid_o) begin
      timeouts++;
      $display("timeout: no write response for index %0d", idx);
    end
    resp_at = cycle;
    if (idx == ctrl_pkg::REG_KCMD) fire_at = resp_at + int'(exp_delay) + 1;
    rng = xorshift32(rng);
    repeat (rng[1:0]) @(negedge clk);  // Stall B
    check_word("bresp_o", 32'(bresp_o), 32'(ctrl_pkg::RESP_OKAY));
    bready_i = 1'b1;
    @(negedge clk);
    bready_i = 1'b0;
  endtask

  task automatic axil_read(input logic [2:0] idx, output logic [31:0] data);
    int n;
    araddr_i  = 32'(idx) << ctrl_pkg::IDX_LSB;
    arvalid_i = 1'b1;
    n = 0;
    while (!arready_o && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!arready_o) begin
      timeouts++;
      $display("timeout: read address channel never became ready");
    end
    @(negedge clk);
    arvalid_i = 1'b0;
    n = 0;
    while (!rvalid_o && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!rvalid_o) begin
      timeouts++;
      $display("timeout: no read data for index %0d", idx);
    end
    rng = xorshift32(rng);
    repeat (rng[1:0]) @(negedge clk);  // Stall R
    data = rdata_o;
    check_word("rresp_o", 32'(rresp_o), 32'(ctrl_pkg::RESP_OKAY));
    rready_i = 1'b1;
    @(negedge clk);
    rready_i = 1'b0;
  endtask

  task automatic wait_launch_done();
    int n;
    n = 0;
    while (cycle <= fire_at && n < 400) begin
      @(negedge clk);
      n++;
    end
    if (cycle <= fire_at) begin
      timeouts++;
      $display("timeout: pending command launch never came due");
    end
  endtask

  ////////////////////////////////////////
  // Protocol and launch checks
  ////////////////////////////////////////
  a_r_hold : assert property (@(posedge clk) disable iff (!rstn)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
    else begin
      assert_errs++;
      $display("read channel dropped rvalid or changed rdata while stalled");
    end

  a_b_hold : assert property (@(posedge clk) disable iff (!rstn)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
    else begin
      assert_errs++;
      $display("write response dropped bvalid or changed bresp while stalled");
    end

  a_launch_time : assert property (@(posedge clk) disable iff (!rstn)
    cmd_valid_o == (cycle == fire_at))
    else begin
      assert_errs++;
      $display("error cmd_valid_o %h expected %h at cycle %0d, launch due at cycle %0d",
               $sampled(cmd_valid_o), $sampled(cycle) == $sampled(fire_at),
               $sampled(cycle), $sampled(fire_at));
    end

  a_launch_payload : assert property (@(posedge clk) disable iff (!rstn)
    cmd_valid_o |-> cmd_o == exp_cmd && data0_o == exp_data0 && data1_o == exp_data1)
    else begin
      assert_errs++;
      $display("error cmd_o %h data0_o %h data1_o %h expected %h %h %h", $sampled(cmd_o),
               $sampled(data0_o), $sampled(data1_o), exp_cmd, exp_data0, exp_data1);
    end

  a_rst_quiet : assert property (@(posedge clk) disable iff (!rstn) quiet |-> !core_rst_o)
    else begin
      assert_errs++;
      $display("error core_rst_o %h expected 0 while the watchdog should be quiet",
               $sampled(core_rst_o));
    end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    logic [31:0] exp;
    int          n;
    int          start;
    rng       = 32'd69823;
    rstn      = 1'b0;
    awaddr_i  = '0;
    araddr_i  = '0;
    wdata_i   = '0;
    wstrb_i   = '1;
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    button_i  = 1'b0;
    quiet     = 1'b0;
    exp_kcmd  = ctrl_pkg::KCMD_RESET_VAL;
    exp_cmd   = '0;
    exp_data0 = '0;
    exp_data1 = '0;
    exp_delay = '0;
    rng = xorshift32(rng);
    status0_i = rng;
    rng = xorshift32(rng);
    status1_i = rng;
    rng = xorshift32(rng);
    status2_i = rng;
    rng = xorshift32(rng);
    status3_i = rng;
    repeat (8) @(negedge clk);
    rstn = 1'b1;

    check_word("arready_o", 32'(arready_o), 32'd1);
    check_word("awready_o", 32'(awready_o), 32'd1);
    check_word("wready_o", 32'(wready_o), 32'd1);
    check_word("rvalid_o", 32'(rvalid_o), 32'd0);
    check_word("bvalid_o", 32'(bvalid_o), 32'd0);
    check_word("cmd_valid_o", 32'(cmd_valid_o), 32'd0);
    check_word("core_rst_o", 32'(core_rst_o), 32'd0);
    check_word("cmd_new", 32'(DUT.u_regs.cmd_new_o), 32'd0);
    check_word("wdt_kick", 32'(DUT.u_regs.wdt_kick_o), 32'd0);
    check_word("wdt_start", 32'(DUT.u_regs.wdt_start_o), 32'd0);
    axil_read(ctrl_pkg::REG_KCMD, rd);
    check_word("rdata_o", rd, ctrl_pkg::KCMD_RESET_VAL);

    // Argument words followed by the read map
    for (int i = 1; i <= 3; i++) begin
      rng = xorshift32(rng);
      axil_write(3'(i), rng);
    end
    rng = xorshift32(rng);
    axil_write(ctrl_pkg::REG_DELAY, {26'd0, rng[5:0]});
    check_word("cmd_o", cmd_o, exp_cmd);
    check_word("data0_o", data0_o, exp_data0);
    check_word("data1_o", data1_o, exp_data1);
    rng = xorshift32(rng);
    axil_write(ctrl_pkg::REG_KCMD, rng);
    for (int i = 0; i < ctrl_pkg::NUM_REGS; i++) begin
      case (i)
        0:       exp = exp_kcmd;
        1:       exp = status0_i;
        2:       exp = status1_i;
        3:       exp = status2_i;
        4:       exp = status3_i;
        default: exp = '0;
      endcase
      axil_read(3'(i), rd);
      check_word("rdata_o", rd, exp);
    end

    // Launches with zero and small random delays
    for (int k = 0; k < 3; k++) begin
      wait_launch_done();
      rng = xorshift32(rng);
      axil_write(ctrl_pkg::REG_DELAY, (k == 0) ? 32'd0 : {28'd0, rng[3:0]});
      rng = xorshift32(rng);
      axil_write(ctrl_pkg::REG_CMD, rng);
      rng = xorshift32(rng);
      axil_write(ctrl_pkg::REG_KCMD, rng);
    end
    wait_launch_done();

    // Watchdog expiry, counted from the cycle start is set
    axil_write(ctrl_pkg::REG_WDT_START, 32'd1);
    while (!core_rst_o && cycle - resp_at < int'(ctrl_pkg::WDT_TIMEOUT_CYCLES) + 4) begin
      @(negedge clk);
    end
    assert (core_rst_o) else begin
      check_errs++;
      $display("core_rst_o did not rise within the watchdog timeout");
    end
    n = 0;
    while (core_rst_o && n < 100) begin
      @(negedge clk);
      n++;
    end
    check_word("core_rst_o pulse length", 32'(n), 32'(ctrl_pkg::WDT_PULSE_CYCLES));

    // Kicks hold the core out of reset
    quiet = 1'b1;
    start = cycle;
    while (cycle - start < 600) begin
      rng = xorshift32(rng);
      axil_write(ctrl_pkg::REG_WDT_KICK, rng | 32'd1);
      repeat (44) @(negedge clk);
    end
    axil_write(ctrl_pkg::REG_WDT_START, 32'd0);
    repeat (400) @(negedge clk);
    quiet = 1'b0;

    button_i = 1'b1;
    @(negedge clk);
    check_word("core_rst_o", 32'(core_rst_o), 32'd1);
    repeat (2) @(negedge clk);
    button_i = 1'b0;
    @(negedge clk);
    check_word("core_rst_o", 32'(core_rst_o), 32'd0);

    $display("assertion errors %0d, check errors %0d, timeouts %0d",
             assert_errs, check_errs, timeouts);
    if (assert_errs == 0 && check_errs == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
common/ctrl_pkg.sv
regs/axil_reg_slave.sv
design/cmd_launch.sv
watchdog/watchdog_timer.sv
design/ctrl_top.sv
tests/tb_ctrl_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_ctrl_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_ctrl_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
exit 0
